// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert
TOP       = periph_tb
FILELIST  = compile.f
BUILD_DIR = obj_dir
RUN_FLAGS = +verilator+error+limit+100
LOG       = sim.log
FAIL_MSG  = Something failed

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: compile
	./$(BUILD_DIR)/V$(TOP) $(RUN_FLAGS) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "Simulation FAILED"; exit 1; fi
	@if ! grep -q "Everything OK" $(LOG); then echo "Simulation did not complete"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: compile.f
rtl/periph_pkg.sv
rtl/wb_addr_decoder.sv
rtl/led_register.sv
rtl/interval_timer.sv
rtl/event_flag.sv
rtl/periph_top.sv
testbench/periph_checker.sv
testbench/periph_tb.sv

// File: rtl/event_flag.sv
// Event flag block

`timescale 1ns/1ps

module event_flag #(
    parameter int FLAG_WIDTH = 32
) (
    input  logic                             clk,
    input  logic                             reset,
    input  logic                             stb_i,
    input  logic                             we_i,
    input  logic [1:0]                       adr_i,
    input  logic [periph_pkg::DAT_WIDTH-1:0] dat_i,
    output logic [periph_pkg::DAT_WIDTH-1:0] dat_o,
    output logic                             ack_o,
    output logic                             irq_o
);

    logic [FLAG_WIDTH-1:0] flags;
    logic [FLAG_WIDTH-1:0] wait_ptn;
    logic                  wait_and;
    logic [FLAG_WIDTH-1:0] hit;
    logic                  wr_en;

    assign wr_en = stb_i && we_i;

    // ----------------------------------------
    // Flag, wait pattern and mode registers
    // ----------------------------------------
    always_ff @(posedge clk) begin
        if (reset) begin
            flags    <= '0;
            wait_ptn <= '0;
            wait_and <= 1'b0;
        end else if (wr_en) begin
            case (adr_i)
                periph_pkg::EVF_SET:  flags    <= flags | dat_i[FLAG_WIDTH-1:0];
                periph_pkg::EVF_CLR:  flags    <= flags & dat_i[FLAG_WIDTH-1:0];
                periph_pkg::EVF_WAIT: wait_ptn <= dat_i[FLAG_WIDTH-1:0];
                periph_pkg::EVF_MODE: wait_and <= dat_i[0];
                default:              flags    <= flags;
            endcase
        end
    end

    // Wait condition
    assign hit   = flags & wait_ptn;
    assign irq_o = (wait_ptn != '0) && (wait_and ? (hit == wait_ptn) : (hit != '0));

    // ----------------------------------------
    // Readback
    // ----------------------------------------
    always_comb begin
        dat_o = '0;
        case (adr_i)
            periph_pkg::EVF_SET,
            periph_pkg::EVF_CLR:  dat_o[FLAG_WIDTH-1:0] = flags;
            periph_pkg::EVF_WAIT: dat_o[FLAG_WIDTH-1:0] = wait_ptn;
            periph_pkg::EVF_MODE: dat_o[0] = wait_and;
            default:              dat_o = '0;
        endcase
    end

    assign ack_o = stb_i;

endmodule

// File: rtl/interval_timer.sv
// Interval timer

`timescale 1ns/1ps

module interval_timer #(
    parameter int TIMER_WIDTH = 32
) (
    input  logic                             clk,
    input  logic                             reset,
    input  logic                             stb_i,
    input  logic                             we_i,
    input  logic [1:0]                       adr_i,
    input  logic [periph_pkg::DAT_WIDTH-1:0] dat_i,
    output logic [periph_pkg::DAT_WIDTH-1:0] dat_o,
    output logic                             ack_o,
    output logic                             irq_o
);

    logic                   enable;
    logic                   irq;
    logic [TIMER_WIDTH-1:0] compare;
    logic [TIMER_WIDTH-1:0] counter;
    logic                   wr_ctrl;
    logic                   wr_compare;
    logic                   wrap;

    assign wr_ctrl    = stb_i && we_i && (adr_i == periph_pkg::TIM_CTRL);
    assign wr_compare = stb_i && we_i && (adr_i == periph_pkg::TIM_COMPARE);
    assign wrap       = enable && (counter == compare);

    // ----------------------------------------
    // Registers
    // ----------------------------------------
    always_ff @(posedge clk) begin
        if (reset) begin
            enable  <= 1'b0;
            compare <= '0;
        end else begin
            if (wr_ctrl) begin
                enable <= dat_i[0];
            end
            if (wr_compare) begin
                compare <= dat_i[TIMER_WIDTH-1:0];
            end
        end
    end

    // Counter wraps to 0 after matching compare
    always_ff @(posedge clk) begin
        if (reset) begin
            counter <= '0;
        end else if (wrap) begin
            counter <= '0;
        end else if (enable) begin
            counter <= counter + 1'b1;
        end
    end

    // Sticky interrupt, a new wrap beats a clear in the same cycle
    always_ff @(posedge clk) begin
        if (reset) begin
            irq <= 1'b0;
        end else if (wrap) begin
            irq <= 1'b1;
        end else if (wr_ctrl && dat_i[1]) begin
            irq <= 1'b0;
        end
    end

    // ----------------------------------------
    // Readback
    // ----------------------------------------
    always_comb begin
        dat_o = '0;
        case (adr_i)
            periph_pkg::TIM_CTRL:    dat_o[1:0] = {irq, enable};
            periph_pkg::TIM_COMPARE: dat_o[TIMER_WIDTH-1:0] = compare;
            periph_pkg::TIM_COUNTER: dat_o[TIMER_WIDTH-1:0] = counter;
            default:                 dat_o = '0;
        endcase
    end

    assign ack_o = stb_i;
    assign irq_o = irq;

endmodule

// File: rtl/led_register.sv
// LED register with blink divider

`timescale 1ns/1ps

module led_register #(
    parameter int BLINK_WIDTH = 26
) (
    input  logic                             clk,
    input  logic                             reset,
    input  logic                             stb_i,
    input  logic                             we_i,
    input  logic [periph_pkg::SEL_WIDTH-1:0] sel_i,
    input  logic [periph_pkg::DAT_WIDTH-1:0] dat_i,
    output logic [periph_pkg::DAT_WIDTH-1:0] dat_o,
    output logic                             ack_o,
    output logic [1:0]                       led_o
);

    logic                   led_bit;
    logic [BLINK_WIDTH-1:0] blink_cnt;

    // Only byte lane 0 can touch the LED bit
    always_ff @(posedge clk) begin
        if (reset) begin
            led_bit <= 1'b0;
        end else if (stb_i && we_i && sel_i[0]) begin
            led_bit <= dat_i[0];
        end
    end

    // Free-running divider
    always_ff @(posedge clk) begin
        if (reset) begin
            blink_cnt <= '0;
        end else begin
            blink_cnt <= blink_cnt + 1'b1;
        end
    end

    assign dat_o = {{(periph_pkg::DAT_WIDTH-1){1'b0}}, led_bit};
    assign ack_o = stb_i;

    assign led_o[0] = led_bit;
    assign led_o[1] = blink_cnt[BLINK_WIDTH-1];

endmodule

// File: rtl/periph_pkg.sv
// Peripheral bus definitions

package periph_pkg;

    // ----------------------------------------
    // Bus widths
    // ----------------------------------------
    parameter int DAT_WIDTH = 32;
    parameter int SEL_WIDTH = DAT_WIDTH / 8;
    // Word address, block field on top of an 8-bit offset
    parameter int ADR_WIDTH = 10;
    parameter int BLK_LSB   = 8;
    parameter int BLK_WIDTH = 2;

    // ----------------------------------------
    // Block select codes
    // ----------------------------------------
    parameter logic [BLK_WIDTH-1:0] BLK_EVFLAG = 2'd0;
    parameter logic [BLK_WIDTH-1:0] BLK_LED    = 2'd1;
    parameter logic [BLK_WIDTH-1:0] BLK_TIMER  = 2'd2;
    // Code 3 is left unmapped

    // ----------------------------------------
    // Register offsets
    // ----------------------------------------
    parameter logic [1:0] TIM_CTRL    = 2'd0;
    parameter logic [1:0] TIM_COMPARE = 2'd1;
    parameter logic [1:0] TIM_COUNTER = 2'd2;

    parameter logic [1:0] EVF_SET  = 2'd0;
    parameter logic [1:0] EVF_CLR  = 2'd1;
    parameter logic [1:0] EVF_WAIT = 2'd2;
    parameter logic [1:0] EVF_MODE = 2'd3;

    parameter logic [1:0] LED_REG = 2'd0;

endpackage

// File: rtl/periph_top.sv
// Peripheral subsystem top

`timescale 1ns/1ps

module periph_top #(
    parameter int BLINK_WIDTH = 26,
    parameter int TIMER_WIDTH = 32,
    parameter int FLAG_WIDTH  = 32
) (
    input  logic                             clk,
    input  logic                             reset,
    input  logic [periph_pkg::ADR_WIDTH-1:0] wb_adr_i,
    input  logic [periph_pkg::DAT_WIDTH-1:0] wb_dat_i,
    output logic [periph_pkg::DAT_WIDTH-1:0] wb_dat_o,
    input  logic                             wb_we_i,
    input  logic [periph_pkg::SEL_WIDTH-1:0] wb_sel_i,
    input  logic                             wb_stb_i,
    output logic                             wb_ack_o,
    output logic [1:0]                       led_o,
    output logic [1:0]                       irq_o
);

    logic                             tim_stb;
    logic                             led_stb;
    logic                             evf_stb;
    logic [periph_pkg::DAT_WIDTH-1:0] tim_dat;
    logic [periph_pkg::DAT_WIDTH-1:0] led_dat;
    logic [periph_pkg::DAT_WIDTH-1:0] evf_dat;
    logic                             tim_ack;
    logic                             led_ack;
    logic                             evf_ack;

    // ----------------------------------------
    // Bus decode
    // ----------------------------------------
    wb_addr_decoder wb_addr_decoder_inst (
        .wb_adr_i  (wb_adr_i),
        .wb_stb_i  (wb_stb_i),
        .tim_stb_o (tim_stb),
        .led_stb_o (led_stb),
        .evf_stb_o (evf_stb),
        .tim_dat_i (tim_dat),
        .led_dat_i (led_dat),
        .evf_dat_i (evf_dat),
        .tim_ack_i (tim_ack),
        .led_ack_i (led_ack),
        .evf_ack_i (evf_ack),
        .wb_dat_o  (wb_dat_o),
        .wb_ack_o  (wb_ack_o)
    );

    // ----------------------------------------
    // Slaves
    // ----------------------------------------
    led_register #(.BLINK_WIDTH(BLINK_WIDTH)) led_register_inst (
        .clk   (clk),
        .reset (reset),
        .stb_i (led_stb),
        .we_i  (wb_we_i),
        .sel_i (wb_sel_i),
        .dat_i (wb_dat_i),
        .dat_o (led_dat),
        .ack_o (led_ack),
        .led_o (led_o)
    );

    interval_timer #(.TIMER_WIDTH(TIMER_WIDTH)) interval_timer_inst (
        .clk   (clk),
        .reset (reset),
        .stb_i (tim_stb),
        .we_i  (wb_we_i),
        .adr_i (wb_adr_i[1:0]),
        .dat_i (wb_dat_i),
        .dat_o (tim_dat),
        .ack_o (tim_ack),
        .irq_o (irq_o[0])
    );

    event_flag #(.FLAG_WIDTH(FLAG_WIDTH)) event_flag_inst (
        .clk   (clk),
        .reset (reset),
        .stb_i (evf_stb),
        .we_i  (wb_we_i),
        .adr_i (wb_adr_i[1:0]),
        .dat_i (wb_dat_i),
        .dat_o (evf_dat),
        .ack_o (evf_ack),
        .irq_o (irq_o[1])
    );

endmodule

// File: rtl/wb_addr_decoder.sv
// Wishbone address decoder

`timescale 1ns/1ps

module wb_addr_decoder (
    input  logic [periph_pkg::ADR_WIDTH-1:0] wb_adr_i,
    input  logic                             wb_stb_i,
    output logic                             tim_stb_o,
    output logic                             led_stb_o,
    output logic                             evf_stb_o,
    input  logic [periph_pkg::DAT_WIDTH-1:0] tim_dat_i,
    input  logic [periph_pkg::DAT_WIDTH-1:0] led_dat_i,
    input  logic [periph_pkg::DAT_WIDTH-1:0] evf_dat_i,
    input  logic                             tim_ack_i,
    input  logic                             led_ack_i,
    input  logic                             evf_ack_i,
    output logic [periph_pkg::DAT_WIDTH-1:0] wb_dat_o,
    output logic                             wb_ack_o
);

    logic [periph_pkg::BLK_WIDTH-1:0] blk;

    assign blk = wb_adr_i[periph_pkg::BLK_LSB +: periph_pkg::BLK_WIDTH];

    // One-hot strobes
    assign tim_stb_o = wb_stb_i && (blk == periph_pkg::BLK_TIMER);
    assign led_stb_o = wb_stb_i && (blk == periph_pkg::BLK_LED);
    assign evf_stb_o = wb_stb_i && (blk == periph_pkg::BLK_EVFLAG);

    // ----------------------------------------
    // Return path
    // ----------------------------------------
    always_comb begin
        case (blk)
            periph_pkg::BLK_TIMER: begin
                wb_dat_o = tim_dat_i;
                wb_ack_o = tim_ack_i;
            end
            periph_pkg::BLK_LED: begin
                wb_dat_o = led_dat_i;
                wb_ack_o = led_ack_i;
            end
            periph_pkg::BLK_EVFLAG: begin
                wb_dat_o = evf_dat_i;
                wb_ack_o = evf_ack_i;
            end
            default: begin
                // Nothing here, answer at once with zero
                wb_dat_o = '0;
                wb_ack_o = wb_stb_i;
            end
        endcase
    end

endmodule

// File: testbench/periph_checker.sv
// Bus and interrupt checker

`timescale 1ns/1ps

module periph_checker (
    input logic                             clk,
    input logic                             reset,
    input logic [periph_pkg::ADR_WIDTH-1:0] wb_adr_i,
    input logic [periph_pkg::DAT_WIDTH-1:0] wb_dat_o,
    input logic                             wb_stb_i,
    input logic                             wb_ack_o,
    input logic [1:0]                       irq_o
);

    int assert_fails = 0;

    // No back-pressure on any address
    ack_follows_stb: assert property (@(posedge clk) wb_ack_o == wb_stb_i)
        else begin
            assert_fails++;
            $error("acknowledge differs from strobe");
        end

    irq_clear_after_reset: assert property (@(posedge clk) reset |=> (irq_o == 2'b00))
        else begin
            assert_fails++;
            $error("interrupt high right after reset");
        end

    // Block code 3 maps to nothing
    unmapped_reads_zero: assert property (@(posedge clk)
        (wb_stb_i && wb_adr_i[periph_pkg::BLK_LSB +: periph_pkg::BLK_WIDTH] == 2'd3)
        |-> (wb_dat_o == '0))
        else begin
            assert_fails++;
            $error("unmapped read returned nonzero data");
        end

endmodule

bind periph_top periph_checker periph_checker_inst (
    .clk      (clk),
    .reset    (reset),
    .wb_adr_i (wb_adr_i),
    .wb_dat_o (wb_dat_o),
    .wb_stb_i (wb_stb_i),
    .wb_ack_o (wb_ack_o),
    .irq_o    (irq_o)
);

// File: testbench/periph_tb.sv
// Peripheral subsystem testbench

`timescale 1ns/1ps

module periph_tb;

    localparam int         BLINK_WIDTH  = 4;
    localparam int         HALF_PERIOD  = 50;
    localparam int         ACK_TIMEOUT  = 4;
    localparam int         TIM_C        = 5;
    localparam logic [1:0] BLK_UNMAPPED = 2'd3;

    logic                             clk;
    logic                             reset;
    logic [periph_pkg::ADR_WIDTH-1:0] wb_adr_i;
    logic [periph_pkg::DAT_WIDTH-1:0] wb_dat_i;
    logic [periph_pkg::DAT_WIDTH-1:0] wb_dat_o;
    logic                             wb_we_i;
    logic [periph_pkg::SEL_WIDTH-1:0] wb_sel_i;
    logic                             wb_stb_i;
    logic                             wb_ack_o;
    logic [1:0]                       led_o;
    logic [1:0]                       irq_o;

    int          errors;
    int          timeouts;
    int          last_wait;
    int          waited;
    logic [31:0] rdata;
    logic [31:0] flags_model;
    logic [31:0] wait_model;
    logic        blink_start;

    periph_top #(.BLINK_WIDTH(BLINK_WIDTH)) periph_top_inst (.*);

    initial begin
        clk = 1'b0;
        forever #HALF_PERIOD clk = ~clk;
    end

    // ----------------------------------------
    // Bus access and checks
    // ----------------------------------------
    function automatic logic [periph_pkg::ADR_WIDTH-1:0] reg_addr(
        input logic [1:0] blk,
        input logic [1:0] off
    );
        return {blk, {(periph_pkg::BLK_LSB-2){1'b0}}, off};
    endfunction

    // One classic cycle with data and ack sampled in the middle of the low phase
    task automatic bus_cycle(
        input  logic [periph_pkg::ADR_WIDTH-1:0] adr,
        input  logic                             we,
        input  logic [31:0]                      dat,
        input  logic [3:0]                       sel,
        output logic [31:0]                      rdat
    );
        @(negedge clk);
        wb_adr_i = adr;
        wb_we_i  = we;
        wb_dat_i = dat;
        wb_sel_i = sel;
        wb_stb_i = 1'b1;
        last_wait = 0;
        #(HALF_PERIOD / 2);
        while (!wb_ack_o && last_wait < ACK_TIMEOUT) begin
            @(negedge clk);
            #(HALF_PERIOD / 2);
            last_wait++;
        end
        if (!wb_ack_o) begin
            timeouts++;
            $display("Timeout: no acknowledge for address %h", adr);
        end
        rdat = wb_dat_o;
        @(negedge clk);
        wb_stb_i = 1'b0;
        wb_we_i  = 1'b0;
    endtask

    task automatic check(input string name, input logic [31:0] exp, input logic [31:0] got);
        assert (got === exp) else begin
            errors++;
            $display("Error: %s expected %h, got %h", name, exp, got);
        end
    endtask

    task automatic write_word(input logic [periph_pkg::ADR_WIDTH-1:0] adr, input logic [31:0] dat);
        logic [31:0] unused;
        bus_cycle(adr, 1'b1, dat, 4'hf, unused);
    endtask

    task automatic check_read(
        input string                             name,
        input logic [periph_pkg::ADR_WIDTH-1:0] adr,
        input logic [31:0]                       exp
    );
        logic [31:0] got;
        bus_cycle(adr, 1'b0, 32'd0, 4'hf, got);
        check(name, exp, got);
    endtask

    task automatic wait_timer_irq(input string name);
        int cycles;
        cycles = 0;
        while (!irq_o[0] && cycles < TIM_C + 2) begin
            @(negedge clk);
            cycles++;
        end
        assert (irq_o[0]) else begin
            errors++;
            $display("Timer interrupt did not rise within %0d cycles (%s)", TIM_C + 2, name);
        end
    endtask

    // Event flag write that also updates the reference state
    task automatic evf_write(input logic [1:0] off, input logic [31:0] dat);
        write_word(reg_addr(periph_pkg::BLK_EVFLAG, off), dat);
        case (off)
            periph_pkg::EVF_SET:  flags_model = flags_model | dat;
            periph_pkg::EVF_CLR:  flags_model = flags_model & dat;
            periph_pkg::EVF_WAIT: wait_model = dat;
        endcase
    endtask

    task automatic check_evf_irq(input string name, input logic exp);
        check(name, 32'(exp), 32'(irq_o[1]));
    endtask

    // ----------------------------------------
    // Stimulus
    // ----------------------------------------
    initial begin
        void'($urandom(32'h53fd77c8));
        errors      = 0;
        timeouts    = 0;
        last_wait   = 0;
        flags_model = '0;
        wait_model  = '0;
        reset       = 1'b1;
        wb_adr_i    = '0;
        wb_dat_i    = '0;
        wb_we_i     = 1'b0;
        wb_sel_i    = '0;
        wb_stb_i    = 1'b0;
        repeat (3) @(negedge clk);
        reset = 1'b0;

        // LED bit, readback and byte lane 0 gating
        write_word(reg_addr(periph_pkg::BLK_LED, periph_pkg::LED_REG), 32'd1);
        check("led output set", 32'd1, 32'(led_o[0]));
        check_read("led readback set", reg_addr(periph_pkg::BLK_LED, periph_pkg::LED_REG), 32'd1);
        write_word(reg_addr(periph_pkg::BLK_LED, periph_pkg::LED_REG), 32'd0);
        check("led output clear", 32'd0, 32'(led_o[0]));
        check_read("led readback clear", reg_addr(periph_pkg::BLK_LED, periph_pkg::LED_REG), 32'd0);
        bus_cycle(reg_addr(periph_pkg::BLK_LED, periph_pkg::LED_REG), 1'b1, 32'd1, 4'b1110, rdata);
        check("led lane 0 off", 32'd0, 32'(led_o[0]));
        check_read("led readback lane 0 off",
                   reg_addr(periph_pkg::BLK_LED, periph_pkg::LED_REG), 32'd0);

        blink_start = led_o[1];
        waited = 0;
        while (led_o[1] == blink_start && waited < 2 ** (BLINK_WIDTH - 1) + 1) begin
            @(negedge clk);
            waited++;
        end
        assert (led_o[1] != blink_start) else begin
            errors++;
            $display("Blink output did not toggle within %0d cycles", waited);
        end

        // Timer wrap, sticky interrupt and clear
        write_word(reg_addr(periph_pkg::BLK_TIMER, periph_pkg::TIM_COMPARE), 32'(TIM_C));
        write_word(reg_addr(periph_pkg::BLK_TIMER, periph_pkg::TIM_CTRL), 32'd1);
        wait_timer_irq("first wrap");
        check_read("timer ctrl status", reg_addr(periph_pkg::BLK_TIMER, periph_pkg::TIM_CTRL), 32'd3);
        repeat (2 * TIM_C) begin
            bus_cycle(reg_addr(periph_pkg::BLK_TIMER, periph_pkg::TIM_COUNTER), 1'b0, 32'd0, 4'hf,
                      rdata);
            assert (rdata <= 32'(TIM_C)) else begin
                errors++;
                $display("Error: timer counter bound expected <= %0d, got %0d", TIM_C, rdata);
            end
        end
        // Stop first so a wrap cannot land on the clear edge
        write_word(reg_addr(periph_pkg::BLK_TIMER, periph_pkg::TIM_CTRL), 32'd0);
        write_word(reg_addr(periph_pkg::BLK_TIMER, periph_pkg::TIM_CTRL), 32'd2);
        check("timer irq cleared", 32'd0, 32'(irq_o[0]));
        check_read("timer ctrl cleared",
                   reg_addr(periph_pkg::BLK_TIMER, periph_pkg::TIM_CTRL), 32'd0);
        write_word(reg_addr(periph_pkg::BLK_TIMER, periph_pkg::TIM_CTRL), 32'd1);
        wait_timer_irq("second wrap");

        // Flag pattern with random set and clear words
        evf_write(periph_pkg::EVF_SET, $urandom);
        check_read("flags after set A",
                   reg_addr(periph_pkg::BLK_EVFLAG, periph_pkg::EVF_SET), flags_model);
        evf_write(periph_pkg::EVF_SET, $urandom);
        check_read("flags after set B",
                   reg_addr(periph_pkg::BLK_EVFLAG, periph_pkg::EVF_SET), flags_model);
        evf_write(periph_pkg::EVF_CLR, $urandom);
        check_read("flags after clear",
                   reg_addr(periph_pkg::BLK_EVFLAG, periph_pkg::EVF_SET), flags_model);
        check_evf_irq("evf irq without wait pattern", 1'b0);

        // Wait condition in both modes with at least two waited bits
        evf_write(periph_pkg::EVF_CLR, 32'd0);
        evf_write(periph_pkg::EVF_WAIT, $urandom | 32'h3);
        evf_write(periph_pkg::EVF_MODE, 32'd0);
        check_evf_irq("evf or mode no flags", 1'b0);
        evf_write(periph_pkg::EVF_SET, wait_model & (~wait_model + 32'd1));
        check_evf_irq("evf or mode one flag", 1'b1);
        evf_write(periph_pkg::EVF_MODE, 32'd1);
        check_evf_irq("evf and mode one flag", 1'b0);
        evf_write(periph_pkg::EVF_SET, wait_model);
        check_evf_irq("evf and mode all flags", 1'b1);
        evf_write(periph_pkg::EVF_WAIT, 32'd0);
        check_evf_irq("evf zero wait pattern", 1'b0);

        // Unmapped block
        check_read("unmapped read", reg_addr(BLK_UNMAPPED, 2'd0), 32'd0);
        check("unmapped ack delay", 32'd0, 32'(last_wait));
        write_word(reg_addr(BLK_UNMAPPED, 2'd0), 32'hffffffff);
        write_word(reg_addr(BLK_UNMAPPED, 2'd1), 32'hffffffff);
        check_read("led after unmapped write",
                   reg_addr(periph_pkg::BLK_LED, periph_pkg::LED_REG), 32'd0);
        check_read("flags after unmapped write",
                   reg_addr(periph_pkg::BLK_EVFLAG, periph_pkg::EVF_SET), flags_model);
        check_read("compare after unmapped write",
                   reg_addr(periph_pkg::BLK_TIMER, periph_pkg::TIM_COMPARE), 32'(TIM_C));

        $display("Run complete: %0d errors, %0d timeouts, %0d checker failures", errors, timeouts,
                 periph_top_inst.periph_checker_inst.assert_fails);
        if (errors == 0 && timeouts == 0
                && periph_top_inst.periph_checker_inst.assert_fails == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule
